/* src/regex_defs.svh */
`ifndef REGEX_DEFS_SVH
`define REGEX_DEFS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////

`define REG_WIDTH           32      // register and bus data
`define MEM_RD_WIDTH        64      // memory read word
`define MEM_RD_ADDR_WIDTH   9       // read address, 64-bit words
`define MEM_WR_ADDR_WIDTH   10      // write address, 32-bit words
`define AXI_ADDR_WIDTH      5       // register window

// longest program the engine will walk
`define MAX_INSTR           256

////////////////////////////////////////
// register window byte offsets
////////////////////////////////////////

`define REG_DATA_IN         5'h00
`define REG_ADDRESS         5'h04
`define REG_START_PTR       5'h08
`define REG_CMD             5'h0C
`define REG_STATUS          5'h10   // read only
`define REG_DATA_OUT        5'h14   // read only

`endif

/* src/regex_pkg.sv */
`include "regex_defs.svh"

package regex_pkg;

    typedef logic [`REG_WIDTH-1:0]         reg_word_t;
    typedef logic [`MEM_RD_WIDTH-1:0]      mem_word_t;  // lowest address in low bits
    typedef logic [`MEM_RD_ADDR_WIDTH-1:0] rd_addr_t;
    typedef logic [`MEM_WR_ADDR_WIDTH-1:0] wr_addr_t;
    typedef logic [7:0]                    char_t;
    typedef logic [15:0]                   instr_t;     // opcode [15:8], char [7:0]

    // full register width so that stray upper bits decode as no command
    typedef enum logic [`REG_WIDTH-1:0] {
        CMD_NOP          = 0,
        CMD_WRITE        = 1,
        CMD_READ         = 2,
        CMD_START        = 3,
        CMD_RESTART      = 4,
        CMD_READ_ELAPSED = 5,
        CMD_RESET        = 6
    } cmd_e;

    typedef enum logic [7:0] {
        OP_CHAR   = 8'd1,
        OP_ANY    = 8'd2,
        OP_ACCEPT = 8'd3
    } op_e;

    typedef enum logic [2:0] {
        STATUS_IDLE     = 3'd0,
        STATUS_RUNNING  = 3'd1,
        STATUS_ACCEPTED = 3'd2,
        STATUS_REJECTED = 3'd3,
        STATUS_ERROR    = 3'd4
    } status_e;

    typedef struct packed {
        reg_word_t data_in;
        reg_word_t address;
        reg_word_t start_ptr;
        reg_word_t cmd;
    } host_regs_t;

    typedef struct packed {
        logic     valid;
        rd_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        wr_addr_t  addr;
        reg_word_t data;
    } mem_wr_t;

    typedef struct packed {
        logic finish;
        logic accept;
        logic error;
    } run_result_t;

endpackage

/* src/axil_regs.sv */
`timescale 1ns/100ps
`include "regex_defs.svh"

module axil_regs
    import regex_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_master,
    input  logic [`AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`REG_WIDTH-1:0]      wdata,
    input  logic [`REG_WIDTH/8-1:0]    wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic                       rvalid,
    output logic [`REG_WIDTH-1:0]      rdata,
    output logic [1:0]                 rresp,
    input  logic                       rready,
    output host_regs_t                 regs,
    input  status_e                    status,
    input  reg_word_t                  data_out
);

logic      wr_fire;
logic      rd_fire;
reg_word_t rd_mux;

// byte lanes of the register follow wstrb
function automatic reg_word_t merge(reg_word_t old_w, reg_word_t new_w,
                                    logic [`REG_WIDTH/8-1:0] strb);
    reg_word_t res;
    res = old_w;
    for (int i = 0; i < `REG_WIDTH/8; i++)
        if (strb[i])
            res[i*8 +: 8] = new_w[i*8 +: 8];
    return res;
endfunction

assign wr_fire = awready && awvalid && wvalid;
assign rd_fire = arready && arvalid;
assign wready  = awready;  // AW and W taken together
assign bresp   = 2'b00;
assign rresp   = 2'b00;

////////////////////////////////////////
// write channel
////////////////////////////////////////

always_ff @(posedge clk)
begin
    if (reset_master)
    begin
        awready <= 1'b0;
        bvalid  <= 1'b0;
        regs    <= '0;
    end
    else
    begin
        awready <= awvalid && wvalid && !bvalid && !awready;  // one cycle pulse
        if (wr_fire)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;

        if (wr_fire)
        begin
            case (awaddr)
                `REG_DATA_IN:   regs.data_in   <= merge(regs.data_in, wdata, wstrb);
                `REG_ADDRESS:   regs.address   <= merge(regs.address, wdata, wstrb);
                `REG_START_PTR: regs.start_ptr <= merge(regs.start_ptr, wdata, wstrb);
                `REG_CMD:       regs.cmd       <= merge(regs.cmd, wdata, wstrb);
                default: ;  // status, data_out and holes
            endcase
        end
    end
end

////////////////////////////////////////
// read channel
////////////////////////////////////////

always_comb
begin
    case (araddr)
        `REG_DATA_IN:   rd_mux = regs.data_in;
        `REG_ADDRESS:   rd_mux = regs.address;
        `REG_START_PTR: rd_mux = regs.start_ptr;
        `REG_CMD:       rd_mux = regs.cmd;
        `REG_STATUS:    rd_mux = reg_word_t'(status);
        `REG_DATA_OUT:  rd_mux = data_out;
        default:        rd_mux = '0;
    endcase
end

always_ff @(posedge clk)
begin
    if (reset_master)
    begin
        arready <= 1'b0;
        rvalid  <= 1'b0;
        rdata   <= '0;
    end
    else
    begin
        arready <= arvalid && !rvalid && !arready;
        if (rd_fire)
        begin
            rvalid <= 1'b1;
            rdata  <= rd_mux;  // sampled at the handshake
        end
        else if (rready)
        begin
            rvalid <= 1'b0;
        end
    end
end

endmodule

/* src/cmd_ctrl.sv */
`timescale 1ns/100ps
`include "regex_defs.svh"

module cmd_ctrl
    import regex_pkg::*;
(
    input  logic        clk,
    input  logic        reset_master,
    input  host_regs_t  regs,
    output status_e     status,
    output reg_word_t   data_out,
    output mem_wr_t     wr,
    output mem_req_t    rd,
    input  mem_word_t   rd_data,
    input  mem_req_t    eng_req,
    output logic        mem_grant,
    output logic        start,
    input  run_result_t result,
    output logic        count_clear,
    output logic        count_run,
    input  reg_word_t   count,
    output logic        core_reset
);

status_e status_nxt;
logic    running;
logic    host_rd;
logic    rd_pend;   // host read word arrives next cycle
logic    rd_half;

assign core_reset  = reset_master || (regs.cmd == CMD_RESET);
assign running     = (status == STATUS_RUNNING);
assign host_rd     = !running && (regs.cmd == CMD_READ);
assign start       = (status == STATUS_IDLE) && (regs.cmd == CMD_START);
assign count_clear = start;
assign count_run   = running;
assign mem_grant   = running;  // engine owns the read port while running

// memory port routing
always_comb
begin
    wr.valid = !running && (regs.cmd == CMD_WRITE);
    wr.addr  = wr_addr_t'(regs.address);
    wr.data  = regs.data_in;

    if (running)
    begin
        rd = eng_req;
    end
    else
    begin
        rd.valid = host_rd;
        rd.addr  = rd_addr_t'(regs.address >> 1);  // two halves per word
    end
end

////////////////////////////////////////
// status FSM
////////////////////////////////////////

always_comb
begin
    status_nxt = status;
    case (status)
        STATUS_IDLE:
            if (start)
                status_nxt = STATUS_RUNNING;
        STATUS_RUNNING:
        begin
            if (result.error)
                status_nxt = STATUS_ERROR;
            else if (result.finish)
                status_nxt = result.accept ? STATUS_ACCEPTED : STATUS_REJECTED;
        end
        STATUS_ACCEPTED, STATUS_REJECTED, STATUS_ERROR:
            if (regs.cmd == CMD_RESTART)
                status_nxt = STATUS_IDLE;
        default:
            status_nxt = STATUS_IDLE;
    endcase
end

always_ff @(posedge clk)
begin
    if (core_reset)
    begin
        status   <= STATUS_IDLE;
        rd_pend  <= 1'b0;
        rd_half  <= 1'b0;
        data_out <= '0;
    end
    else
    begin
        status  <= status_nxt;
        rd_pend <= host_rd;
        rd_half <= regs.address[0];
        if (rd_pend)
            data_out <= rd_half ? rd_data[`REG_WIDTH +: `REG_WIDTH] : rd_data[0 +: `REG_WIDTH];
        else if (regs.cmd == CMD_READ_ELAPSED)
            data_out <= count;
    end
end

endmodule

/* src/cycle_counter.sv */
`timescale 1ns/100ps

module cycle_counter
    import regex_pkg::*;
(
    input  logic      clk,
    input  logic      core_reset,
    input  logic      clear,
    input  logic      run,
    output reg_word_t count
);

// run length in cycles, sticks at all ones
always_ff @(posedge clk)
begin
    if (core_reset || clear)
    begin
        count <= '0;
    end
    else if (run && !(&count))
    begin
        count <= count + 1'b1;
    end
end

endmodule

/* src/match_bram.sv */
`timescale 1ns/100ps
`include "regex_defs.svh"

module match_bram
    import regex_pkg::*;
(
    input  logic      clk,
    input  mem_wr_t   wr,
    input  mem_req_t  rd,
    output mem_word_t rd_data
);

mem_word_t mem [2**`MEM_RD_ADDR_WIDTH];
rd_addr_t  wr_row;

assign wr_row = rd_addr_t'(wr.addr >> 1);

// write lands in one half, even address in the low bits
always_ff @(posedge clk)
begin
    if (wr.valid)
    begin
        if (wr.addr[0])
            mem[wr_row][`REG_WIDTH +: `REG_WIDTH] <= wr.data;
        else
            mem[wr_row][0 +: `REG_WIDTH] <= wr.data;
    end
end

// one cycle read latency
always_ff @(posedge clk)
begin
    if (rd.valid)
    begin
        rd_data <= mem[rd.addr];
    end
end

endmodule

/* src/match_engine.sv */
`timescale 1ns/100ps
`include "regex_defs.svh"

module match_engine
    import regex_pkg::*;
(
    input  logic        clk,
    input  logic        core_reset,
    input  logic        start,
    input  reg_word_t   start_ptr,
    output mem_req_t    req,
    input  logic        grant,
    input  mem_word_t   rd_data,
    output run_result_t result
);

typedef enum logic [2:0] {
    S_IDLE,
    S_IFETCH,   // instruction request
    S_IWAIT,    // instruction word back, decode
    S_TFETCH,   // text request
    S_TCMP      // text word back, compare
} eng_state_e;

eng_state_e                  state;
logic [$clog2(`MAX_INSTR):0] pc;
logic [$clog2(`MAX_INSTR):0] pc_nxt;
reg_word_t                   ptr;   // text byte address
instr_t                      instr;
instr_t                      instr_q;
op_e                         op;
char_t                       text_ch;
logic                        miss;

assign pc_nxt  = pc + 1'b1;
assign instr   = rd_data[pc[1:0]*16 +: 16];  // four instructions per word
assign op      = op_e'(instr[15:8]);
assign text_ch = rd_data[ptr[2:0]*8 +: 8];
// zero byte ends the text
assign miss = (text_ch == '0) ||
              ((op_e'(instr_q[15:8]) == OP_CHAR) && (text_ch != instr_q[7:0]));

always_comb
begin
    req.valid = (state == S_IFETCH) || (state == S_TFETCH);
    if (state == S_TFETCH)
        req.addr = rd_addr_t'(ptr >> 3);
    else
        req.addr = rd_addr_t'(pc >> 2);
end

always_ff @(posedge clk)
begin
    if (state == S_IWAIT)
        instr_q <= instr;
end

always_ff @(posedge clk)
begin
    if (core_reset)
    begin
        state  <= S_IDLE;
        pc     <= '0;
        ptr    <= '0;
        result <= '0;
    end
    else if (start)
    begin
        state  <= S_IFETCH;
        pc     <= '0;
        ptr    <= start_ptr;
        result <= '0;
    end
    else
    begin
        case (state)
            S_IFETCH:
                if (grant)
                    state <= S_IWAIT;
            S_IWAIT:
            begin
                case (op)
                    OP_CHAR, OP_ANY:
                        state <= S_TFETCH;
                    OP_ACCEPT:
                    begin
                        result.finish <= 1'b1;
                        result.accept <= 1'b1;
                        state         <= S_IDLE;
                    end
                    default:
                    begin
                        result.error <= 1'b1;  // unknown opcode
                        state        <= S_IDLE;
                    end
                endcase
            end
            S_TFETCH:
                if (grant)
                    state <= S_TCMP;
            S_TCMP:
            begin
                if (miss)
                begin
                    result.finish <= 1'b1;
                    state         <= S_IDLE;
                end
                else if (pc_nxt == `MAX_INSTR)
                begin
                    result.error <= 1'b1;  // ran off the program
                    state        <= S_IDLE;
                end
                else
                begin
                    pc    <= pc_nxt;
                    ptr   <= ptr + 1'b1;
                    state <= S_IFETCH;
                end
            end
            default:
                state <= S_IDLE;
        endcase
    end
end

endmodule

/* src/regex_accel_top.sv */
`timescale 1ns/100ps
`include "regex_defs.svh"

module regex_accel_top
    import regex_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset_master,
    input  logic [`AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`REG_WIDTH-1:0]      wdata,
    input  logic [`REG_WIDTH/8-1:0]    wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic                       bvalid,
    output logic [1:0]                 bresp,
    input  logic                       bready,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic                       rvalid,
    output logic [`REG_WIDTH-1:0]      rdata,
    output logic [1:0]                 rresp,
    input  logic                       rready
);

host_regs_t  regs;
status_e     status;
reg_word_t   data_out;
mem_wr_t     wr;
mem_req_t    rd;
mem_req_t    eng_req;
mem_word_t   rd_data;
logic        mem_grant;
logic        start;
run_result_t result;
logic        count_clear;
logic        count_run;
reg_word_t   count;
logic        core_reset;

////////////////////////////////////////
// host side
////////////////////////////////////////

axil_regs u_axil_regs (
    .clk          (clk),
    .reset_master (reset_master),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rresp        (rresp),
    .rready       (rready),
    .regs         (regs),
    .status       (status),
    .data_out     (data_out)
);

cmd_ctrl u_cmd_ctrl (
    .clk          (clk),
    .reset_master (reset_master),
    .regs         (regs),
    .status       (status),
    .data_out     (data_out),
    .wr           (wr),
    .rd           (rd),
    .rd_data      (rd_data),
    .eng_req      (eng_req),
    .mem_grant    (mem_grant),
    .start        (start),
    .result       (result),
    .count_clear  (count_clear),
    .count_run    (count_run),
    .count        (count),
    .core_reset   (core_reset)
);

////////////////////////////////////////
// core
////////////////////////////////////////

cycle_counter u_cycle_counter (
    .clk        (clk),
    .core_reset (core_reset),
    .clear      (count_clear),
    .run        (count_run),
    .count      (count)
);

match_bram u_match_bram (
    .clk     (clk),
    .wr      (wr),
    .rd      (rd),
    .rd_data (rd_data)
);

match_engine u_match_engine (
    .clk        (clk),
    .core_reset (core_reset),
    .start      (start),
    .start_ptr  (regs.start_ptr),
    .req        (eng_req),
    .grant      (mem_grant),
    .rd_data    (rd_data),
    .result     (result)
);

endmodule

/* tests/tb_regex_accel.sv */
`timescale 1ns/100ps
`include "regex_defs.svh"

module tb_regex_accel
    import regex_pkg::*;
;

localparam int HALF_PERIOD     = 4;
localparam int CLK_PERIOD      = 2 * HALF_PERIOD;
localparam int HS_LIMIT        = 50;     // cycles per bus handshake
localparam int POLL_LIMIT      = 200;    // status reads per run
localparam int TEXT_BASE       = 512;    // text byte address, clear of the programs
// about 400 bus accesses at up to ~60 cycles each
localparam int WATCHDOG_CYCLES = 25000;

logic                       clk;
logic                       reset_master;
logic [`AXI_ADDR_WIDTH-1:0] awaddr;
logic                       awvalid;
logic                       awready;
logic [`REG_WIDTH-1:0]      wdata;
logic [`REG_WIDTH/8-1:0]    wstrb;
logic                       wvalid;
logic                       wready;
logic                       bvalid;
logic [1:0]                 bresp;
logic                       bready;
logic [`AXI_ADDR_WIDTH-1:0] araddr;
logic                       arvalid;
logic                       arready;
logic                       rvalid;
logic [`REG_WIDTH-1:0]      rdata;
logic [1:0]                 rresp;
logic                       rready;

int        seed = 15655;
reg_word_t saved_words [8];   // kept for the soft reset test

regex_accel_top uut (
    .clk          (clk),
    .reset_master (reset_master),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rvalid       (rvalid),
    .rdata        (rdata),
    .rresp        (rresp),
    .rready       (rready)
);

always #HALF_PERIOD clk = ~clk;

////////////////////////////////////////
// failure reporting and compares
////////////////////////////////////////

task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1);
endtask

task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
    if (act !== exp)
    begin
        $display("Error: %s expected %h actual %h", name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_status(input string name, input status_e exp, input status_e act);
    if (act !== exp)
    begin
        $display("Error: %s expected %s (%0d) actual %s (%0d)",
                 name, exp.name(), exp, act.name(), act);
        stop_with_failure();
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
    begin
        $display("Error: %s expected %b actual %b", name, exp, act);
        stop_with_failure();
    end
endtask

task automatic check_count_range(input string name, input reg_word_t lo, input reg_word_t hi,
                                 input reg_word_t act);
    if (act < lo || act > hi)
    begin
        $display("Error: %s expected %0d to %0d actual %0d", name, lo, hi, act);
        stop_with_failure();
    end
endtask

////////////////////////////////////////
// AXI4-Lite driver
////////////////////////////////////////

task automatic wait_cycle_limited(input int waited, input string what);
    if (waited > HS_LIMIT)
    begin
        $display("no response from the DUT on %s", what);
        stop_with_failure();
    end
endtask

task automatic axil_write(input logic [`AXI_ADDR_WIDTH-1:0] addr, input reg_word_t data);
    int waited;
    waited  = 0;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (!(awready && wready))
    begin
        @(negedge clk);
        waited++;
        wait_cycle_limited(waited, "the write address and data channels");
    end
    @(negedge clk);   // taken at the edge just passed
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
    begin
        @(negedge clk);
        waited++;
        wait_cycle_limited(waited, "the write response channel");
    end
    check_resp("write response", 2'b00, bresp);
    @(negedge clk);
    bready = 1'b0;
endtask

// stall holds rready low for that many cycles once rvalid is up
task automatic axil_read(input logic [`AXI_ADDR_WIDTH-1:0] addr, output reg_word_t data,
                         input int stall);
    int waited;
    waited  = 0;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    while (!arready)
    begin
        @(negedge clk);
        waited++;
        wait_cycle_limited(waited, "the read address channel");
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid)
    begin
        @(negedge clk);
        waited++;
        wait_cycle_limited(waited, "the read data channel");
    end
    repeat (stall) @(negedge clk);
    if (!rvalid)
    begin
        $display("read response dropped while rready was held low");
        stop_with_failure();
    end
    check_resp("read response", 2'b00, rresp);
    data   = rdata;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
endtask

////////////////////////////////////////
// register level helpers
////////////////////////////////////////

task automatic set_cmd(input cmd_e c);
    axil_write(`REG_CMD, reg_word_t'(c));
endtask

task automatic read_status(output status_e st);
    reg_word_t w;
    axil_read(`REG_STATUS, w, 0);
    st = status_e'(w[2:0]);
endtask

task automatic mem_write(input wr_addr_t a, input reg_word_t d);
    axil_write(`REG_DATA_IN, d);
    axil_write(`REG_ADDRESS, reg_word_t'(a));
    set_cmd(CMD_WRITE);
    set_cmd(CMD_NOP);
endtask

task automatic mem_read(input wr_addr_t a, output reg_word_t d, input int stall);
    axil_write(`REG_ADDRESS, reg_word_t'(a));
    set_cmd(CMD_READ);   // data_out settles two cycles in
    set_cmd(CMD_NOP);
    axil_read(`REG_DATA_OUT, d, stall);
endtask

function automatic instr_t make_instr(input logic [7:0] op, input char_t c);
    return {op, c};
endfunction

function automatic char_t random_text_byte();
    return char_t'(($unsigned($random(seed)) % 255) + 1);  // never zero
endfunction

// two instructions per 32-bit word, even one low
task automatic load_program(input instr_t prog[$]);
    instr_t lo;
    instr_t hi;
    for (int k = 0; k < (prog.size() + 1) / 2; k++)
    begin
        lo = prog[2*k];
        hi = (2*k + 1 < prog.size()) ? prog[2*k + 1] : 16'h0000;
        mem_write(wr_addr_t'(k), {hi, lo});
    end
endtask

// text plus at least one zero byte after it
task automatic load_text(input char_t txt[$]);
    reg_word_t w;
    for (int k = 0; k < txt.size() / 4 + 1; k++)
    begin
        w = '0;
        for (int j = 0; j < 4; j++)
            if (4*k + j < txt.size())
                w[j*8 +: 8] = txt[4*k + j];
        mem_write(wr_addr_t'(TEXT_BASE / 4 + k), w);
    end
endtask

////////////////////////////////////////
// reference matcher
////////////////////////////////////////

function automatic status_e ref_match(input instr_t prog[$], input char_t txt[$],
                                      output int fetches);
    status_e    res;
    logic       done;
    int         pc;
    int         tp;
    logic [7:0] op;
    char_t      c;
    char_t      ch;
    res     = STATUS_ERROR;
    done    = 1'b0;
    pc      = 0;
    tp      = 0;
    fetches = 0;
    while (!done)
    begin
        op = (pc < prog.size()) ? prog[pc][15:8] : 8'h00;
        c  = (pc < prog.size()) ? prog[pc][7:0] : 8'h00;
        fetches++;   // instruction fetch
        if (op == OP_ACCEPT)
        begin
            res  = STATUS_ACCEPTED;
            done = 1'b1;
        end
        else if (op == OP_CHAR || op == OP_ANY)
        begin
            fetches++;   // text fetch
            ch = (tp < txt.size()) ? txt[tp] : 8'h00;
            if (ch == 8'h00 || (op == OP_CHAR && ch != c))
            begin
                res  = STATUS_REJECTED;
                done = 1'b1;
            end
            else if (pc + 1 == `MAX_INSTR)
            begin
                res  = STATUS_ERROR;
                done = 1'b1;
            end
            else
            begin
                pc++;
                tp++;
            end
        end
        else
        begin
            res  = STATUS_ERROR;
            done = 1'b1;
        end
    end
    return res;
endfunction

task automatic run_program(input string name, input instr_t prog[$], input char_t txt[$],
                           output int fetches);
    status_e exp;
    status_e st;
    int      polls;
    exp = ref_match(prog, txt, fetches);
    load_program(prog);
    load_text(txt);
    axil_write(`REG_START_PTR, reg_word_t'(TEXT_BASE));
    set_cmd(CMD_START);
    set_cmd(CMD_NOP);
    polls = 0;
    read_status(st);
    while (st == STATUS_RUNNING)
    begin
        polls++;
        if (polls > POLL_LIMIT)
        begin
            $display("%s: the match run never left RUNNING", name);
            stop_with_failure();
        end
        read_status(st);
    end
    check_status(name, exp, st);
endtask

task automatic restart_to_idle(input string name);
    status_e st;
    set_cmd(CMD_RESTART);
    set_cmd(CMD_NOP);
    read_status(st);
    check_status(name, STATUS_IDLE, st);
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////

task automatic access_memory_words();
    reg_word_t w;
    status_e   st;
    for (int i = 0; i < 8; i++)
    begin
        saved_words[i] = $random(seed);
        mem_write(wr_addr_t'(900 + i), saved_words[i]);
    end
    for (int i = 0; i < 8; i++)   // both halves of four words
    begin
        mem_read(wr_addr_t'(900 + i), w, 0);
        check_word("memory readback", saved_words[i], w);
    end
    axil_write(`REG_START_PTR, 32'h0000_0abc);
    axil_read(`REG_START_PTR, w, 0);
    check_word("start_ptr readback", 32'h0000_0abc, w);
    read_status(st);
    check_status("status after reset", STATUS_IDLE, st);
endtask

task automatic match_accepting_text();
    instr_t prog[$];
    char_t  txt[$];
    int     fetches;
    for (int i = 0; i < 6; i++)
        txt.push_back(random_text_byte());
    prog.push_back(make_instr(OP_CHAR, txt[0]));
    prog.push_back(make_instr(OP_ANY, 8'h00));
    prog.push_back(make_instr(OP_CHAR, txt[2]));
    prog.push_back(make_instr(OP_ANY, 8'h00));
    prog.push_back(make_instr(OP_CHAR, txt[4]));
    prog.push_back(make_instr(OP_ACCEPT, 8'h00));
    run_program("accepting match", prog, txt, fetches);
    restart_to_idle("restart after accept");
endtask

task automatic reject_bad_text();
    instr_t prog[$];
    char_t  txt[$];
    int     fetches;
    // second character differs
    prog.push_back(make_instr(OP_CHAR, 8'h61));
    prog.push_back(make_instr(OP_CHAR, 8'h62));
    prog.push_back(make_instr(OP_ACCEPT, 8'h00));
    txt.push_back(8'h61);
    txt.push_back(8'h78);
    run_program("character mismatch", prog, txt, fetches);
    restart_to_idle("restart after mismatch");

    // zero byte reached before ACCEPT
    prog.delete();
    txt.delete();
    repeat (3) prog.push_back(make_instr(OP_ANY, 8'h00));
    prog.push_back(make_instr(OP_ACCEPT, 8'h00));
    txt.push_back(8'h61);
    txt.push_back(8'h62);
    run_program("text too short", prog, txt, fetches);
    restart_to_idle("restart after short text");
endtask

task automatic flag_unknown_opcode();
    instr_t prog[$];
    char_t  txt[$];
    int     fetches;
    prog.push_back(make_instr(OP_CHAR, 8'h61));
    prog.push_back(make_instr(8'h7f, 8'h00));
    prog.push_back(make_instr(OP_ACCEPT, 8'h00));
    txt.push_back(8'h61);
    txt.push_back(8'h62);
    run_program("unknown opcode", prog, txt, fetches);
    restart_to_idle("restart after error");
endtask

task automatic measure_elapsed_count();
    instr_t    prog[$];
    char_t     txt[$];
    int        fetches;
    reg_word_t w;
    for (int i = 0; i < 5; i++)
    begin
        txt.push_back(random_text_byte());
        prog.push_back(make_instr(OP_ANY, 8'h00));
    end
    prog.push_back(make_instr(OP_ACCEPT, 8'h00));
    run_program("elapsed run", prog, txt, fetches);
    set_cmd(CMD_READ_ELAPSED);
    set_cmd(CMD_NOP);
    axil_read(`REG_DATA_OUT, w, 0);
    check_count_range("elapsed count", reg_word_t'(2 * fetches), reg_word_t'(2 * fetches + 8), w);
    restart_to_idle("restart after elapsed");
endtask

task automatic soft_reset_midrun();
    instr_t    prog[$];
    char_t     txt[$];
    status_e   st;
    reg_word_t w;
    // long enough to still be running when the reset lands
    for (int i = 0; i < 40; i++)
    begin
        txt.push_back(random_text_byte());
        prog.push_back(make_instr(OP_ANY, 8'h00));
    end
    prog.push_back(make_instr(OP_ACCEPT, 8'h00));
    load_program(prog);
    load_text(txt);
    axil_write(`REG_START_PTR, reg_word_t'(TEXT_BASE));
    set_cmd(CMD_START);
    read_status(st);
    check_status("running before soft reset", STATUS_RUNNING, st);
    set_cmd(CMD_RESET);
    set_cmd(CMD_NOP);
    read_status(st);
    check_status("idle after soft reset", STATUS_IDLE, st);

    // memory survives, reads under rready stall
    mem_read(wr_addr_t'(0), w, 5);
    check_word("program kept after reset", {prog[1], prog[0]}, w);
    mem_read(wr_addr_t'(903), w, 5);
    check_word("data kept after reset", saved_words[3], w);
endtask

////////////////////////////////////////
// main sequence and watchdog
////////////////////////////////////////

initial
begin
    clk          = 1'b0;
    reset_master = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    repeat (3) @(negedge clk);
    reset_master = 1'b0;

    access_memory_words();
    match_accepting_text();
    reject_bad_text();
    flag_unknown_opcode();
    measure_elapsed_count();
    soft_reset_midrun();

    $display("Finished with no errors");
    $finish;
end

initial
begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    stop_with_failure();
end

endmodule

/* sim.f */
+incdir+src
src/regex_pkg.sv
src/axil_regs.sv
src/cmd_ctrl.sv
src/cycle_counter.sv
src/match_bram.sv
src/match_engine.sv
src/regex_accel_top.sv
tests/tb_regex_accel.sv

/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = tb_regex_accel
RTL_TOP    = regex_accel_top
FILELIST   = sim.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
